/* hdl/umi_pkg.sv */
/*
 * UMI command format
 * Opcode encodings and field positions of the 32-bit UMI command word.
 * Only the single-beat read and write subset is served by the target.
 */
package umi_pkg;

   localparam int UMI_CW = 32;          // Fixed by the command format

   // Command opcodes, bits 4..0 of the command word
   typedef enum logic [4:0] {
      REQ_INVALID      = 5'h00,
      REQ_READ         = 5'h01,
      RESP_READ        = 5'h02,
      REQ_WRITE        = 5'h03,        // Non-posted, gets a response
      RESP_WRITE       = 5'h04,
      REQ_WRITE_POSTED = 5'h05,        // Fire and forget
      REQ_ATOMIC       = 5'h09         // Not served here
   } umi_opcode_e;

   //########################################
   // Field positions
   //########################################
   localparam int UMI_OPCODE_LSB = 0;
   localparam int UMI_OPCODE_MSB = 4;
   localparam int UMI_SIZE_LSB   = 5;  // log2 of bytes per beat
   localparam int UMI_SIZE_MSB   = 7;
   localparam int UMI_LEN_LSB    = 8;  // Beats minus one
   localparam int UMI_LEN_MSB    = 15;
   localparam int UMI_HOSTID_LSB = 16;
   localparam int UMI_HOSTID_MSB = 20;

endpackage

/* hdl/mem_pkg.sv */
/*
 * Local memory definitions
 * Access size encoding, word geometry and the byte-lane mask rule
 * shared by the SRAM and its reference model.
 */
package mem_pkg;

   localparam int MEM_DW        = 32;                  // Word width
   localparam int MEM_LANES     = MEM_DW / 8;          // Byte lanes per word
   localparam int MEM_LANE_BITS = $clog2(MEM_LANES);   // Address bits below the word
   localparam int MEM_DEPTH     = 256;                 // Words

   // Access size, same coding as the UMI size field
   typedef enum logic [2:0] {
      SIZE_BYTE = 3'd0,
      SIZE_HALF = 3'd1,
      SIZE_WORD = 3'd2
   } mem_size_e;

   // Lanes touched by an access of a given size at a given byte offset
   function automatic logic [MEM_LANES-1:0] size_to_mask(
      input mem_size_e                size,
      input logic [MEM_LANE_BITS-1:0] offset);
      logic [MEM_LANES-1:0] mask;
      case (size)
         SIZE_BYTE: mask = MEM_LANES'(1) << offset;
         SIZE_HALF: mask = MEM_LANES'(3) << (offset & ~MEM_LANE_BITS'(1));  // Half aligned
         SIZE_WORD: mask = '1;
         default:   mask = '1;         // Wider sizes clip to one word
      endcase
      return mask;
   endfunction

endpackage

/* hdl/umi_cmd_codec.sv */
/*
 * UMI command codec
 * Splits a request command into opcode and size, classifies it as
 * read, write or posted write, and builds the response command by
 * replacing the opcode. Other fields pass through unchanged.
 */
`timescale 1ns/1ns

module umi_cmd_codec
   (
   input  logic [umi_pkg::UMI_CW-1:0] cmd,
   input  umi_pkg::umi_opcode_e       resp_opcode,
   output umi_pkg::umi_opcode_e       opcode,
   output mem_pkg::mem_size_e         size,
   output logic                       is_read,
   output logic                       is_write,     // Posted or not
   output logic                       is_posted,
   output logic [umi_pkg::UMI_CW-1:0] resp_cmd
   );
   import umi_pkg::*;
   import mem_pkg::*;

   // Field slicing
   assign opcode = umi_opcode_e'(cmd[UMI_OPCODE_MSB:UMI_OPCODE_LSB]);
   assign size   = mem_size_e'(cmd[UMI_SIZE_MSB:UMI_SIZE_LSB]);

   // Request class, anything else is dropped
   assign is_read   = (opcode == REQ_READ);
   assign is_posted = (opcode == REQ_WRITE_POSTED);
   assign is_write  = (opcode == REQ_WRITE) || is_posted;

   // Response command
   always_comb
   begin
      resp_cmd = cmd;                                       // QoS, prot, hostid kept
      resp_cmd[UMI_OPCODE_MSB:UMI_OPCODE_LSB] = resp_opcode;
      resp_cmd[UMI_LEN_MSB:UMI_LEN_LSB]       = '0;         // Always one beat back
   end

endmodule

/* hdl/umi_endpoint.sv */
/*
 * UMI memory endpoint
 * Turns one UMI device request into one local memory access and
 * returns the response with swapped addresses and the memory data.
 * One response in flight. Response valid rises 1 + REG cycles after
 * the request is accepted. REG adds a register on the read data.
 */
`timescale 1ns/1ns

module umi_endpoint
  #(parameter int AW  = 32,
    parameter int DW  = 32,
    parameter int REG = 1)
   (
   input  logic                       clk,
   input  logic                       nreset,
   // Device request
   input  logic                       udev_req_valid,
   input  logic [umi_pkg::UMI_CW-1:0] udev_req_cmd,
   input  logic [AW-1:0]              udev_req_dstaddr,
   input  logic [AW-1:0]              udev_req_srcaddr,
   input  logic [DW-1:0]              udev_req_data,
   output logic                       udev_req_ready,
   // Device response
   output logic                       udev_resp_valid,
   output logic [umi_pkg::UMI_CW-1:0] udev_resp_cmd,
   output logic [AW-1:0]              udev_resp_dstaddr,
   output logic [AW-1:0]              udev_resp_srcaddr,
   output logic [DW-1:0]              udev_resp_data,
   input  logic                       udev_resp_ready,
   // Local memory side
   output logic                       loc_req,
   output logic                       loc_write,
   output logic [AW-1:0]              loc_addr,
   output mem_pkg::mem_size_e         loc_size,
   output logic [DW-1:0]              loc_wrdata,
   input  logic                       loc_gnt,
   input  logic [DW-1:0]              loc_rddata
   );
   import umi_pkg::*;

   umi_opcode_e       opcode;
   umi_opcode_e       resp_opcode;
   logic              is_read;
   logic              is_write;
   logic              is_posted;
   logic [UMI_CW-1:0] resp_cmd;
   logic              slot_free;       // Room for one more response
   logic              accept;
   logic              accept_resp;     // Accepted and owes a response
   logic [REG:0]      vld_sr;          // Bit 0 marks the SRAM data cycle
   logic              hold_q;          // Response stalled by the device
   logic [UMI_CW-1:0] cmd_q;
   logic [AW-1:0]     dstaddr_q;
   logic [AW-1:0]     srcaddr_q;
   logic [DW-1:0]     data_q;

   umi_cmd_codec i_codec
      (.cmd         (udev_req_cmd),
       .resp_opcode (resp_opcode),
       .opcode      (opcode),
       .size        (loc_size),
       .is_read     (is_read),
       .is_write    (is_write),
       .is_posted   (is_posted),
       .resp_cmd    (resp_cmd));

   assign resp_opcode = (opcode == REQ_READ) ? RESP_READ : RESP_WRITE;

   //########################################
   // Request side
   //########################################
   // Empty, or the pending response leaves this cycle
   assign slot_free = (~|vld_sr & ~hold_q) | (udev_resp_valid & udev_resp_ready);

   // Unsupported opcodes still take one memory slot as a discarded read
   assign loc_req        = udev_req_valid & slot_free;
   assign loc_write      = is_write;
   assign loc_addr       = udev_req_dstaddr;
   assign loc_wrdata     = udev_req_data;     // Already lane aligned
   assign udev_req_ready = loc_gnt & slot_free;

   assign accept      = udev_req_valid & udev_req_ready;
   assign accept_resp = accept & (is_read | (is_write & ~is_posted));

   //########################################
   // Response side
   //########################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         vld_sr <= '0;
         hold_q <= 1'b0;
      end
      else
      begin
         vld_sr[0] <= accept_resp;
         for (int i = 1; i <= REG; i++)
            vld_sr[i] <= vld_sr[i-1];                      // Extra data stage
         hold_q <= udev_resp_valid & ~udev_resp_ready;
      end
   end

   assign udev_resp_valid = vld_sr[REG] | hold_q;

   // Header fields taken at acceptance, data when the SRAM returns it
   always_ff @(posedge clk)
   begin
      if (accept_resp)
      begin
         cmd_q     <= resp_cmd;
         dstaddr_q <= udev_req_srcaddr;                    // Back to the requester
         srcaddr_q <= udev_req_dstaddr;
      end
      if (vld_sr[0])
         data_q <= loc_rddata;                             // SRAM output lives one cycle
   end

   if (REG != 0)
   begin : g_pipe
      assign udev_resp_data = data_q;
   end
   else
   begin : g_bypass
      assign udev_resp_data = vld_sr[0] ? loc_rddata : data_q;   // Held copy on stall
   end

   assign udev_resp_cmd     = cmd_q;
   assign udev_resp_dstaddr = dstaddr_q;
   assign udev_resp_srcaddr = srcaddr_q;

   // No new memory request while the previous response is still on its way
   assert property (@(posedge clk) disable iff (!nreset)
      ($past(accept_resp) || udev_resp_valid) && !(udev_resp_valid && udev_resp_ready)
         |-> !loc_req);

   // Stalled response keeps its fields
   assert property (@(posedge clk) disable iff (!nreset)
      $past(udev_resp_valid && !udev_resp_ready) |->
         udev_resp_valid && $stable(udev_resp_cmd) && $stable(udev_resp_data));

endmodule

/* hdl/mem_arbiter.sv */
/*
 * Shared memory arbiter
 * Grants one of two endpoints the SRAM port in the same cycle as the
 * request. Contention alternates using one bit of last-grant state.
 */
`timescale 1ns/1ns

module mem_arbiter
  #(parameter int AW = 32,
    parameter int DW = 32)
   (
   input  logic               clk,
   input  logic               nreset,
   // Port 0
   input  logic               req0,
   input  logic               write0,
   input  logic [AW-1:0]      addr0,
   input  mem_pkg::mem_size_e size0,
   input  logic [DW-1:0]      wdata0,
   output logic               gnt0,
   // Port 1
   input  logic               req1,
   input  logic               write1,
   input  logic [AW-1:0]      addr1,
   input  mem_pkg::mem_size_e size1,
   input  logic [DW-1:0]      wdata1,
   output logic               gnt1,
   // Memory port
   output logic               mem_en,
   output logic               mem_we,
   output logic [AW-1:0]      mem_addr,
   output mem_pkg::mem_size_e mem_size,
   output logic [DW-1:0]      mem_wdata
   );

   logic last_q;                       // Port 1 took the last grant

   // Loser of the last round wins a tie
   assign gnt0 = req0 & (~req1 | last_q);
   assign gnt1 = req1 & (~req0 | ~last_q);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         last_q <= 1'b0;
      else if (gnt0 | gnt1)
         last_q <= gnt1;
   end

   // Winner onto the SRAM port
   assign mem_en    = gnt0 | gnt1;
   assign mem_we    = gnt1 ? write1 : write0;
   assign mem_addr  = gnt1 ? addr1  : addr0;
   assign mem_size  = gnt1 ? size1  : size0;
   assign mem_wdata = gnt1 ? wdata1 : wdata0;

   assert property (@(posedge clk) disable iff (!nreset) !(gnt0 && gnt1));

endmodule

/* hdl/local_sram.sv */
/*
 * Local SRAM
 * Word array with byte-lane writes. Every enabled access registers
 * the old word on rdata one cycle later, so writes read first.
 */
`timescale 1ns/1ns

module local_sram
  #(parameter int AW    = 32,
    parameter int DW    = mem_pkg::MEM_DW,
    parameter int DEPTH = mem_pkg::MEM_DEPTH)
   (
   input  logic               clk,
   input  logic               nreset,
   input  logic               en,
   input  logic               we,
   input  logic [AW-1:0]      addr,    // Byte address
   input  mem_pkg::mem_size_e size,
   input  logic [DW-1:0]      wdata,   // Bytes at their lanes
   output logic [DW-1:0]      rdata
   );
   import mem_pkg::*;

   localparam int IW = $clog2(DEPTH);

   logic [DW-1:0]        mem [DEPTH];
   logic [IW-1:0]        index;
   logic [MEM_LANES-1:0] wmask;

   if (DW != 8 * MEM_LANES)
   begin : g_dw_check
      $error("Data width does not match the memory lane count");
   end

   assign index = addr[MEM_LANE_BITS +: IW];                     // Word index
   assign wmask = size_to_mask(size, addr[MEM_LANE_BITS-1:0]);

   always_ff @(posedge clk)
   begin
      if (en)
      begin
         rdata <= mem[index];                                    // Old word
         if (we)
            for (int i = 0; i < MEM_LANES; i++)
               if (wmask[i])
                  mem[index][8*i +: 8] <= wdata[8*i +: 8];
      end
   end

   // Address map of the top level fits the array
   assert property (@(posedge clk) disable iff (!nreset)
      en |-> addr[AW-1:MEM_LANE_BITS] < DEPTH);

endmodule

/* hdl/umi_mem_subsys.sv */
/*
 * UMI memory subsystem
 * Two UMI device ports, each with its own endpoint, sharing one
 * local SRAM through a round-robin arbiter.
 */
`timescale 1ns/1ns

module umi_mem_subsys
  #(parameter int AW    = 32,
    parameter int DW    = mem_pkg::MEM_DW,
    parameter int DEPTH = mem_pkg::MEM_DEPTH,
    parameter int REG   = 1)
   (
   input  logic                       clk,
   input  logic                       nreset,
   // Device 0
   input  logic                       udev0_req_valid,
   input  logic [umi_pkg::UMI_CW-1:0] udev0_req_cmd,
   input  logic [AW-1:0]              udev0_req_dstaddr,
   input  logic [AW-1:0]              udev0_req_srcaddr,
   input  logic [DW-1:0]              udev0_req_data,
   output logic                       udev0_req_ready,
   output logic                       udev0_resp_valid,
   output logic [umi_pkg::UMI_CW-1:0] udev0_resp_cmd,
   output logic [AW-1:0]              udev0_resp_dstaddr,
   output logic [AW-1:0]              udev0_resp_srcaddr,
   output logic [DW-1:0]              udev0_resp_data,
   input  logic                       udev0_resp_ready,
   // Device 1
   input  logic                       udev1_req_valid,
   input  logic [umi_pkg::UMI_CW-1:0] udev1_req_cmd,
   input  logic [AW-1:0]              udev1_req_dstaddr,
   input  logic [AW-1:0]              udev1_req_srcaddr,
   input  logic [DW-1:0]              udev1_req_data,
   output logic                       udev1_req_ready,
   output logic                       udev1_resp_valid,
   output logic [umi_pkg::UMI_CW-1:0] udev1_resp_cmd,
   output logic [AW-1:0]              udev1_resp_dstaddr,
   output logic [AW-1:0]              udev1_resp_srcaddr,
   output logic [DW-1:0]              udev1_resp_data,
   input  logic                       udev1_resp_ready
   );
   import mem_pkg::*;

   // Endpoints to arbiter
   logic          loc_req0;
   logic          loc_req1;
   logic          loc_write0;
   logic          loc_write1;
   logic [AW-1:0] loc_addr0;
   logic [AW-1:0] loc_addr1;
   mem_size_e     loc_size0;
   mem_size_e     loc_size1;
   logic [DW-1:0] loc_wrdata0;
   logic [DW-1:0] loc_wrdata1;
   logic          loc_gnt0;
   logic          loc_gnt1;
   // Arbiter to SRAM
   logic          mem_en;
   logic          mem_we;
   logic [AW-1:0] mem_addr;
   mem_size_e     mem_size;
   logic [DW-1:0] mem_wdata;
   logic [DW-1:0] mem_rdata;                  // Fanned out to both endpoints

   umi_endpoint #(.AW(AW), .DW(DW), .REG(REG)) i_ep0
      (.clk (clk), .nreset (nreset),
       .udev_req_valid    (udev0_req_valid),    .udev_req_cmd      (udev0_req_cmd),
       .udev_req_dstaddr  (udev0_req_dstaddr),  .udev_req_srcaddr  (udev0_req_srcaddr),
       .udev_req_data     (udev0_req_data),     .udev_req_ready    (udev0_req_ready),
       .udev_resp_valid   (udev0_resp_valid),   .udev_resp_cmd     (udev0_resp_cmd),
       .udev_resp_dstaddr (udev0_resp_dstaddr), .udev_resp_srcaddr (udev0_resp_srcaddr),
       .udev_resp_data    (udev0_resp_data),    .udev_resp_ready   (udev0_resp_ready),
       .loc_req (loc_req0), .loc_write (loc_write0), .loc_addr (loc_addr0),
       .loc_size (loc_size0), .loc_wrdata (loc_wrdata0),
       .loc_gnt (loc_gnt0), .loc_rddata (mem_rdata));

   umi_endpoint #(.AW(AW), .DW(DW), .REG(REG)) i_ep1
      (.clk (clk), .nreset (nreset),
       .udev_req_valid    (udev1_req_valid),    .udev_req_cmd      (udev1_req_cmd),
       .udev_req_dstaddr  (udev1_req_dstaddr),  .udev_req_srcaddr  (udev1_req_srcaddr),
       .udev_req_data     (udev1_req_data),     .udev_req_ready    (udev1_req_ready),
       .udev_resp_valid   (udev1_resp_valid),   .udev_resp_cmd     (udev1_resp_cmd),
       .udev_resp_dstaddr (udev1_resp_dstaddr), .udev_resp_srcaddr (udev1_resp_srcaddr),
       .udev_resp_data    (udev1_resp_data),    .udev_resp_ready   (udev1_resp_ready),
       .loc_req (loc_req1), .loc_write (loc_write1), .loc_addr (loc_addr1),
       .loc_size (loc_size1), .loc_wrdata (loc_wrdata1),
       .loc_gnt (loc_gnt1), .loc_rddata (mem_rdata));

   mem_arbiter #(.AW(AW), .DW(DW)) i_arb
      (.clk (clk), .nreset (nreset),
       .req0 (loc_req0), .write0 (loc_write0), .addr0 (loc_addr0),
       .size0 (loc_size0), .wdata0 (loc_wrdata0), .gnt0 (loc_gnt0),
       .req1 (loc_req1), .write1 (loc_write1), .addr1 (loc_addr1),
       .size1 (loc_size1), .wdata1 (loc_wrdata1), .gnt1 (loc_gnt1),
       .mem_en (mem_en), .mem_we (mem_we), .mem_addr (mem_addr),
       .mem_size (mem_size), .mem_wdata (mem_wdata));

   local_sram #(.AW(AW), .DW(DW), .DEPTH(DEPTH)) i_sram
      (.clk (clk), .nreset (nreset),
       .en (mem_en), .we (mem_we), .addr (mem_addr), .size (mem_size),
       .wdata (mem_wdata), .rdata (mem_rdata));

endmodule

/* verif/tb_umi_mem_subsys.sv */
/*
 * Testbench for the UMI memory subsystem
 * Drives both device ports with directed and random single-beat
 * reads and writes and keeps a reference copy of the SRAM.
 * Responses are checked in acceptance order under random back-pressure.
 */
`timescale 1ns/1ns

module tb_umi_mem_subsys;
   import umi_pkg::*;
   import mem_pkg::*;

   localparam int     AW      = 32;
   localparam int     DW      = 32;
   localparam int     DEPTH   = 256;
   localparam int     IW      = $clog2(DEPTH);
   localparam int     N_WORDS = 16;                          // Words set up front
   localparam int     N_RAND  = 40;                          // Random requests per port
   localparam int     N_TRANS = N_WORDS + 2 + 12 + 3 + 2 * N_RAND;
   localparam int     TIMEOUT = 20 * N_TRANS + 100;          // Cycles for the whole run
   localparam int     STARVE  = 40;                          // Longest wait for req_ready
   localparam integer SEED    = 32'hd2575579;

   typedef struct packed {
      logic [UMI_CW-1:0] cmd;
      logic [AW-1:0]     dstaddr;
      logic [AW-1:0]     srcaddr;
      logic [DW-1:0]     data;
   } resp_t;

   logic              clk;
   logic              nreset;
   logic [1:0]        req_valid;
   logic [UMI_CW-1:0] req_cmd [2];
   logic [AW-1:0]     req_dstaddr [2];
   logic [AW-1:0]     req_srcaddr [2];
   logic [DW-1:0]     req_data [2];
   logic [1:0]        req_ready;
   logic [1:0]        resp_valid;
   logic [UMI_CW-1:0] resp_cmd [2];
   logic [AW-1:0]     resp_dstaddr [2];
   logic [AW-1:0]     resp_srcaddr [2];
   logic [DW-1:0]     resp_data [2];
   logic [1:0]        resp_ready = 2'b11;

   logic [DW-1:0]     ref_mem [DEPTH];                       // Reference copy of the SRAM
   resp_t             exp_q0 [$];
   resp_t             exp_q1 [$];
   resp_t             held [2];                              // Stalled response fields
   logic [1:0]        held_valid = 2'b00;
   logic              stall_en = 1'b0;                       // Random resp_ready
   integer            seed = SEED;
   integer            ready_seed = SEED ^ 32'h0000_0001;
   int                cycle_count = 0;
   logic [UMI_CW-1:0] rnd_cmd [2][N_RAND];
   logic [AW-1:0]     rnd_dst [2][N_RAND];
   logic [AW-1:0]     rnd_src [2][N_RAND];
   logic [DW-1:0]     rnd_data [2][N_RAND];

   umi_mem_subsys #(.AW(AW), .DW(DW), .DEPTH(DEPTH), .REG(1)) i_dut
      (.clk (clk), .nreset (nreset),
       .udev0_req_valid    (req_valid[0]),    .udev0_req_cmd      (req_cmd[0]),
       .udev0_req_dstaddr  (req_dstaddr[0]),  .udev0_req_srcaddr  (req_srcaddr[0]),
       .udev0_req_data     (req_data[0]),     .udev0_req_ready    (req_ready[0]),
       .udev0_resp_valid   (resp_valid[0]),   .udev0_resp_cmd     (resp_cmd[0]),
       .udev0_resp_dstaddr (resp_dstaddr[0]), .udev0_resp_srcaddr (resp_srcaddr[0]),
       .udev0_resp_data    (resp_data[0]),    .udev0_resp_ready   (resp_ready[0]),
       .udev1_req_valid    (req_valid[1]),    .udev1_req_cmd      (req_cmd[1]),
       .udev1_req_dstaddr  (req_dstaddr[1]),  .udev1_req_srcaddr  (req_srcaddr[1]),
       .udev1_req_data     (req_data[1]),     .udev1_req_ready    (req_ready[1]),
       .udev1_resp_valid   (resp_valid[1]),   .udev1_resp_cmd     (resp_cmd[1]),
       .udev1_resp_dstaddr (resp_dstaddr[1]), .udev1_resp_srcaddr (resp_srcaddr[1]),
       .udev1_resp_data    (resp_data[1]),    .udev1_resp_ready   (resp_ready[1]));

   always #50 clk = ~clk;                                    // 100 ns period

   //########################################
   // Reference model
   //########################################
   function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] addr);
      return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
   endfunction

   // One lane at the offset, an aligned pair, or the full word
   function automatic logic [3:0] byte_enables(input mem_size_e size, input logic [1:0] offset);
      case (size)
         SIZE_BYTE: return 4'b0001 << offset;
         SIZE_HALF: return offset[1] ? 4'b1100 : 4'b0011;
         default:   return 4'b1111;
      endcase
   endfunction

   function automatic logic [UMI_CW-1:0] make_cmd(input umi_opcode_e op, input mem_size_e size,
                                                  input logic [4:0] hostid);
      logic [UMI_CW-1:0] cmd;
      cmd = '0;                                              // len 0, one beat
      cmd[UMI_OPCODE_MSB:UMI_OPCODE_LSB] = op;
      cmd[UMI_SIZE_MSB:UMI_SIZE_LSB]     = size;
      cmd[UMI_HOSTID_MSB:UMI_HOSTID_LSB] = hostid;
      return cmd;
   endfunction

   // Response owed for a request, memory data as of acceptance
   function automatic resp_t expected_response(input logic [UMI_CW-1:0] cmd,
                                               input logic [AW-1:0] dstaddr,
                                               input logic [AW-1:0] srcaddr);
      resp_t       r;
      umi_opcode_e op;
      op = umi_opcode_e'(cmd[UMI_OPCODE_MSB:UMI_OPCODE_LSB]);
      r.cmd = cmd;
      r.cmd[UMI_OPCODE_MSB:UMI_OPCODE_LSB] = (op == REQ_READ) ? RESP_READ : RESP_WRITE;
      r.dstaddr = srcaddr;                                   // Addresses swap
      r.srcaddr = dstaddr;
      r.data    = ref_mem[dstaddr[2 +: IW]];                 // Old word for writes too
      return r;
   endfunction

   // Model update on an accepted request
   task automatic record_accept(input int p);
      umi_opcode_e op;
      logic [3:0]  be;
      int          idx;
      op  = umi_opcode_e'(req_cmd[p][UMI_OPCODE_MSB:UMI_OPCODE_LSB]);
      idx = int'(req_dstaddr[p][2 +: IW]);
      if (op == REQ_READ || op == REQ_WRITE)
      begin
         if (p == 0)
            exp_q0.push_back(expected_response(req_cmd[p], req_dstaddr[p], req_srcaddr[p]));
         else
            exp_q1.push_back(expected_response(req_cmd[p], req_dstaddr[p], req_srcaddr[p]));
      end
      if (op == REQ_WRITE || op == REQ_WRITE_POSTED)
      begin
         be = byte_enables(mem_size_e'(req_cmd[p][UMI_SIZE_MSB:UMI_SIZE_LSB]),
                           req_dstaddr[p][1:0]);
         for (int i = 0; i < 4; i++)
            if (be[i])
               ref_mem[idx][8*i +: 8] = req_data[p][8*i +: 8];
      end
   endtask

   //########################################
   // Checks
   //########################################
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_cmd(input string name, input logic [UMI_CW-1:0] got,
                            input logic [UMI_CW-1:0] want);
      umi_opcode_e got_op;
      umi_opcode_e want_op;
      got_op  = umi_opcode_e'(got[UMI_OPCODE_MSB:UMI_OPCODE_LSB]);
      want_op = umi_opcode_e'(want[UMI_OPCODE_MSB:UMI_OPCODE_LSB]);
      if (got_op !== want_op)
         stop_run($sformatf("Mismatch at time %0t: %s opcode got %h expected %h",
                            $time, name, got_op, want_op));
      else if (got !== want)
         stop_run($sformatf("Mismatch at time %0t: %s got %h expected %h",
                            $time, name, got, want));
   endtask

   task automatic check_addr(input string name, input logic [AW-1:0] got,
                             input logic [AW-1:0] want);
      if (got !== want)
         stop_run($sformatf("Mismatch at time %0t: %s got %h expected %h",
                            $time, name, got, want));
   endtask

   task automatic check_data(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] want);
      if (got !== want)
         stop_run($sformatf("Mismatch at time %0t: %s got %h expected %h",
                            $time, name, got, want));
   endtask

   task automatic compare_fields(input int p, input resp_t got, input resp_t want);
      check_cmd($sformatf("udev%0d_resp_cmd", p), got.cmd, want.cmd);
      check_addr($sformatf("udev%0d_resp_dstaddr", p), got.dstaddr, want.dstaddr);
      check_addr($sformatf("udev%0d_resp_srcaddr", p), got.srcaddr, want.srcaddr);
      check_data($sformatf("udev%0d_resp_data", p), got.data, want.data);
   endtask

   // Sampled on the rising edge, fields stable since the falling edge
   task automatic watch_response(input int p);
      resp_t got;
      resp_t want;
      got = {resp_cmd[p], resp_dstaddr[p], resp_srcaddr[p], resp_data[p]};
      if (held_valid[p])
      begin
         if (!resp_valid[p])
            stop_run($sformatf("Response on udev%0d withdrawn while stalled", p));
         else
            compare_fields(p, got, held[p]);                 // Must not move while stalled
      end
      if (resp_valid[p] && !resp_ready[p])
      begin
         held[p]       = got;
         held_valid[p] = 1'b1;
      end
      else if (resp_valid[p])
      begin
         held_valid[p] = 1'b0;
         if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0))
            stop_run($sformatf("Unexpected response on udev%0d at time %0t", p, $time));
         else
         begin
            if (p == 0)
               want = exp_q0.pop_front();
            else
               want = exp_q1.pop_front();
            compare_fields(p, got, want);
         end
      end
   endtask

   always @(posedge clk)
      if (nreset)
         watch_response(0);

   always @(posedge clk)
      if (nreset)
         watch_response(1);

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT)
         stop_run($sformatf("Timeout after %0d cycles", cycle_count));
   end

   // Device side back-pressure
   always @(negedge clk)
   begin
      if (stall_en)
      begin
         resp_ready[0] = ($random(ready_seed) % 4) != 0;
         resp_ready[1] = ($random(ready_seed) % 4) != 0;
      end
      else
         resp_ready = 2'b11;
   end

   //########################################
   // Stimulus
   //########################################
   task automatic send_request(input int p, input logic [UMI_CW-1:0] cmd,
                               input logic [AW-1:0] dstaddr, input logic [AW-1:0] srcaddr,
                               input logic [DW-1:0] data);
      int waited;
      waited = 0;
      @(negedge clk);
      req_valid[p]   = 1'b1;
      req_cmd[p]     = cmd;
      req_dstaddr[p] = dstaddr;
      req_srcaddr[p] = srcaddr;
      req_data[p]    = data;
      @(posedge clk);
      while (!req_ready[p])
      begin
         waited++;
         if (waited > STARVE)
            stop_run($sformatf("Request on udev%0d not accepted within %0d cycles", p, STARVE));
         else
            @(posedge clk);
      end
      record_accept(p);                                     // Accepted on this edge
   endtask

   task automatic release_request(input int p);
      @(negedge clk);
      req_valid[p] = 1'b0;
   endtask

   task automatic wait_responses();
      int n;
      n = 0;
      while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < 50)
      begin
         @(posedge clk);
         n++;
      end
   endtask

   // Overlapping words 8..15 on both ports
   task automatic build_random();
      umi_opcode_e op;
      mem_size_e   size;
      logic [1:0]  off;
      for (int p = 0; p < 2; p++)
         for (int i = 0; i < N_RAND; i++)
         begin
            case ($random(seed) & 3)
               1:       op = REQ_WRITE;
               2:       op = REQ_WRITE_POSTED;
               default: op = REQ_READ;
            endcase
            case ($random(seed) & 3)
               0:       size = SIZE_BYTE;
               1:       size = SIZE_HALF;
               default: size = SIZE_WORD;
            endcase
            off = 2'($random(seed));
            if (size == SIZE_HALF)
               off[0] = 1'b0;
            else if (size == SIZE_WORD)
               off = 2'b00;
            rnd_cmd[p][i]        = make_cmd(op, size, 5'($random(seed)));
            rnd_cmd[p][i][31:21] = 11'($random(seed));       // Pass-through bits
            rnd_dst[p][i]        = {{(AW-6){1'b0}}, 1'b1, 3'($random(seed)), off};
            rnd_src[p][i]        = $random(seed);
            rnd_data[p][i]       = $random(seed);
         end
   endtask

   task automatic run_random(input int p);
      for (int i = 0; i < N_RAND; i++)
         send_request(p, rnd_cmd[p][i], rnd_dst[p][i], rnd_src[p][i], rnd_data[p][i]);
      release_request(p);
   endtask

   initial
   begin
      clk       = 1'b0;
      nreset    = 1'b0;
      req_valid = 2'b00;
      for (int p = 0; p < 2; p++)
      begin
         req_cmd[p]     = '0;
         req_dstaddr[p] = '0;
         req_srcaddr[p] = '0;
         req_data[p]    = '0;
      end
      build_random();
      repeat (4) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;

      // Known contents by posted writes, no responses expected
      for (int w = 0; w < N_WORDS; w++)
         send_request(0, make_cmd(REQ_WRITE_POSTED, SIZE_WORD, 5'd1), AW'(4 * w),
                      32'h9000_0000, fill_word(AW'(4 * w)));
      release_request(0);

      // Word write then read back
      send_request(0, make_cmd(REQ_WRITE, SIZE_WORD, 5'd2), 32'h20, 32'h8000_0100, 32'hcafe_f00d);
      send_request(0, make_cmd(REQ_READ, SIZE_WORD, 5'd2), 32'h20, 32'h8000_0200, '0);
      release_request(0);

      // Byte lanes, then halves
      for (int off = 0; off < 4; off++)
      begin
         send_request(1, make_cmd(REQ_WRITE, SIZE_BYTE, 5'd3), AW'(16 + off),
                      32'h7000_0010, 32'ha1b2_c3d4 ^ {4{8'(off)}});
         send_request(1, make_cmd(REQ_READ, SIZE_WORD, 5'd3), 32'h10, 32'h7000_0020, '0);
      end
      for (int off = 0; off < 4; off += 2)
      begin
         send_request(1, make_cmd(REQ_WRITE, SIZE_HALF, 5'd4), AW'(20 + off),
                      32'h7000_0030, 32'h5e6f_7a8b + off);
         send_request(1, make_cmd(REQ_READ, SIZE_WORD, 5'd4), 32'h14, 32'h7000_0040, '0);
      end
      release_request(1);

      // Posted write and an atomic, only the read answers
      send_request(0, make_cmd(REQ_WRITE_POSTED, SIZE_WORD, 5'd5), 32'h24, 32'h6000_0000,
                   32'h0bad_f00d);
      send_request(0, make_cmd(REQ_ATOMIC, SIZE_WORD, 5'd5), 32'h24, 32'h6000_0004,
                   32'hdead_beef);
      send_request(0, make_cmd(REQ_READ, SIZE_WORD, 5'd5), 32'h24, 32'h6000_0008, '0);
      release_request(0);
      wait_responses();

      // Both ports at once with back-pressure
      stall_en = 1'b1;
      fork
         run_random(0);
         run_random(1);
      join
      stall_en = 1'b0;
      wait_responses();

      if (exp_q0.size() == 0 && exp_q1.size() == 0)
      begin
         $display("Simulation passed");
         $finish;
      end
      else
         stop_run($sformatf("Responses missing at the end, %0d on udev0 and %0d on udev1",
                            exp_q0.size(), exp_q1.size()));
   end

endmodule

/* list.f */
hdl/umi_pkg.sv
hdl/mem_pkg.sv
hdl/umi_cmd_codec.sv
hdl/umi_endpoint.sv
hdl/mem_arbiter.sv
hdl/local_sram.sv
hdl/umi_mem_subsys.sv
verif/tb_umi_mem_subsys.sv

/* run.sh */
#!/bin/bash
# Build and run the UMI memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f list.f --top-module tb_umi_mem_subsys \
   --Mdir obj_dir -o tb_umi_mem_subsys

# A fatal stop exits non-zero, the log search gives the verdict
./obj_dir/tb_umi_mem_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0
